//--- src/riscv_em_pkg.sv
`default_nettype none
package riscv_em_pkg;

    typedef logic [63:0] xlen_t;
    typedef logic [4:0]  regaddr_t;
    typedef logic [1:0]  resultsrc_t;
    typedef logic [1:0]  storesrc_t;
    typedef logic [2:0]  memext_t;
    typedef logic [7:0]  byteen_t;
    typedef logic [3:0]  trap_cause_t;

    localparam resultsrc_t RES_ALU    = 2'd0;
    localparam resultsrc_t RES_LOAD   = 2'd1;
    localparam resultsrc_t RES_PCPLUS4 = 2'd2;
    localparam resultsrc_t RES_IMM    = 2'd3;

    localparam storesrc_t ST_BYTE   = 2'd0;
    localparam storesrc_t ST_HALF   = 2'd1;
    localparam storesrc_t ST_WORD   = 2'd2;
    localparam storesrc_t ST_DOUBLE = 2'd3;

    localparam memext_t EXT_LB  = 3'd0;
    localparam memext_t EXT_LH  = 3'd1;
    localparam memext_t EXT_LW  = 3'd2;
    localparam memext_t EXT_LD  = 3'd3;
    localparam memext_t EXT_LBU = 3'd4;
    localparam memext_t EXT_LHU = 3'd5;
    localparam memext_t EXT_LWU = 3'd6;

    localparam trap_cause_t CAUSE_ILLEGAL    = 4'd2;
    localparam trap_cause_t CAUSE_LOAD_MISAL = 4'd4;
    localparam trap_cause_t CAUSE_STORE_MISAL = 4'd6;
    localparam trap_cause_t CAUSE_ECALL_M    = 4'd11;

    typedef enum logic {S_IDLE, S_LOAD_WAIT} ctrl_state_t;

endpackage
`default_nettype wire

//--- src/riscv_em_ppreg.sv
`default_nettype none
module riscv_em_ppreg (
    input  wire logic                     i_riscv_em_clk,
    input  wire logic                     i_riscv_em_rst,
    input  wire logic                     i_riscv_em_stall,
    input  wire logic                     i_riscv_em_flush,
    input  wire logic                     i_riscv_em_regw_e,
    input  wire riscv_em_pkg::resultsrc_t i_riscv_em_resultsrc_e,
    input  wire riscv_em_pkg::storesrc_t  i_riscv_em_storesrc_e,
    input  wire riscv_em_pkg::memext_t    i_riscv_em_memext_e,
    input  wire logic                     i_riscv_em_memread_e,
    input  wire logic                     i_riscv_em_memwrite_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_pc_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_pcplus4_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_result_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_storedata_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_imm_e,
    input  wire riscv_em_pkg::regaddr_t   i_riscv_em_rdaddr_e,
    input  wire logic                     i_riscv_em_ecall_m_e,
    input  wire logic                     i_riscv_em_illegal_inst_e,
    input  wire logic                     i_riscv_em_load_addr_misaligned_e,
    input  wire logic                     i_riscv_em_store_addr_misaligned_e,
    input  wire logic                     i_riscv_em_instret_e,
    output riscv_em_pkg::xlen_t           o_riscv_em_pc_m,
    output logic                          o_riscv_em_regw_m,
    output riscv_em_pkg::resultsrc_t      o_riscv_em_resultsrc_m,
    output riscv_em_pkg::storesrc_t       o_riscv_em_storesrc_m,
    output riscv_em_pkg::memext_t         o_riscv_em_memext_m,
    output logic                          o_riscv_em_memread_m,
    output logic                          o_riscv_em_memwrite_m,
    output riscv_em_pkg::xlen_t           o_riscv_em_pcplus4_m,
    output riscv_em_pkg::xlen_t           o_riscv_em_result_m,
    output riscv_em_pkg::xlen_t           o_riscv_em_storedata_m,
    output riscv_em_pkg::xlen_t           o_riscv_em_imm_m,
    output riscv_em_pkg::regaddr_t        o_riscv_em_rdaddr_m,
    output logic                          o_riscv_em_ecall_m_m,
    output logic                          o_riscv_em_illegal_inst_m,
    output logic                          o_riscv_em_load_addr_misaligned_m,
    output logic                          o_riscv_em_store_addr_misaligned_m,
    output logic                          o_riscv_em_instret_m
);

    localparam int W = 5 * $bits(riscv_em_pkg::xlen_t) + $bits(riscv_em_pkg::regaddr_t)
                     + $bits(riscv_em_pkg::resultsrc_t) + $bits(riscv_em_pkg::storesrc_t)
                     + $bits(riscv_em_pkg::memext_t) + 8;

    logic [W-1:0] stage_d;
    logic [W-1:0] stage_q;

    assign stage_d = {i_riscv_em_pc_e, i_riscv_em_regw_e, i_riscv_em_resultsrc_e,
                      i_riscv_em_storesrc_e, i_riscv_em_memext_e, i_riscv_em_memread_e,
                      i_riscv_em_memwrite_e, i_riscv_em_pcplus4_e, i_riscv_em_result_e,
                      i_riscv_em_storedata_e, i_riscv_em_imm_e, i_riscv_em_rdaddr_e,
                      i_riscv_em_ecall_m_e, i_riscv_em_illegal_inst_e,
                      i_riscv_em_load_addr_misaligned_e, i_riscv_em_store_addr_misaligned_e,
                      i_riscv_em_instret_e};

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
            stage_q <= '0;
        else if (i_riscv_em_flush) // flush beats stall
            stage_q <= '0;
        else if (!i_riscv_em_stall)
            stage_q <= stage_d;
    end

    assign {o_riscv_em_pc_m, o_riscv_em_regw_m, o_riscv_em_resultsrc_m,
            o_riscv_em_storesrc_m, o_riscv_em_memext_m, o_riscv_em_memread_m,
            o_riscv_em_memwrite_m, o_riscv_em_pcplus4_m, o_riscv_em_result_m,
            o_riscv_em_storedata_m, o_riscv_em_imm_m, o_riscv_em_rdaddr_m,
            o_riscv_em_ecall_m_m, o_riscv_em_illegal_inst_m,
            o_riscv_em_load_addr_misaligned_m, o_riscv_em_store_addr_misaligned_m,
            o_riscv_em_instret_m} = stage_q;

endmodule
`default_nettype wire

//--- src/riscv_em_store_align.sv
`default_nettype none
module riscv_em_store_align (
    input  wire riscv_em_pkg::storesrc_t i_riscv_em_storesrc,
    input  wire logic [2:0]              i_riscv_em_addr_lo,
    input  wire riscv_em_pkg::xlen_t     i_riscv_em_storedata,
    output riscv_em_pkg::byteen_t        o_riscv_em_byteen,
    output riscv_em_pkg::xlen_t          o_riscv_em_wdata
);

    riscv_em_pkg::byteen_t size_mask;

    always_comb
    begin
        case (i_riscv_em_storesrc)
            riscv_em_pkg::ST_BYTE:
            begin
                size_mask        = 8'h01;
                o_riscv_em_wdata = {8{i_riscv_em_storedata[7:0]}};
            end
            riscv_em_pkg::ST_HALF:
            begin
                size_mask        = 8'h03;
                o_riscv_em_wdata = {4{i_riscv_em_storedata[15:0]}};
            end
            riscv_em_pkg::ST_WORD:
            begin
                size_mask        = 8'h0f;
                o_riscv_em_wdata = {2{i_riscv_em_storedata[31:0]}};
            end
            default:
            begin
                size_mask        = 8'hff;
                o_riscv_em_wdata = i_riscv_em_storedata;
            end
        endcase
    end

    assign o_riscv_em_byteen = size_mask << i_riscv_em_addr_lo; // lanes of this access only

endmodule
`default_nettype wire

//--- src/riscv_em_dmem.sv
`default_nettype none
module riscv_em_dmem #(
    parameter int DMEM_WORDS = 64
) (
    input  wire logic                  i_riscv_em_clk,
    input  wire logic                  i_riscv_em_we,
    input  wire riscv_em_pkg::byteen_t i_riscv_em_byteen,
    input  wire riscv_em_pkg::xlen_t   i_riscv_em_addr,
    input  wire riscv_em_pkg::xlen_t   i_riscv_em_wdata,
    output riscv_em_pkg::xlen_t        o_riscv_em_rdata
);

    localparam int AW = $clog2(DMEM_WORDS);

    riscv_em_pkg::xlen_t mem [DMEM_WORDS];
    logic [AW-1:0]       index;

    assign index = i_riscv_em_addr[AW+2:3]; // word index above the byte offset

    always_ff @(posedge i_riscv_em_clk)
    begin
        if (i_riscv_em_we)
        begin
            for (int b = 0; b < 8; b++)
            begin
                if (i_riscv_em_byteen[b])
                    mem[index][b*8 +: 8] <= i_riscv_em_wdata[b*8 +: 8];
            end
        end
        o_riscv_em_rdata <= mem[index]; // old data on a same-edge write
    end

endmodule
`default_nettype wire

//--- src/riscv_em_load_ext.sv
`default_nettype none
module riscv_em_load_ext (
    input  wire riscv_em_pkg::memext_t i_riscv_em_memext,
    input  wire logic [2:0]            i_riscv_em_addr_lo,
    input  wire riscv_em_pkg::xlen_t   i_riscv_em_rdata,
    output riscv_em_pkg::xlen_t        o_riscv_em_loaddata
);

    riscv_em_pkg::xlen_t shifted;

    assign shifted = i_riscv_em_rdata >> {i_riscv_em_addr_lo, 3'b000}; // lane 0 holds the data

    always_comb
    begin
        case (i_riscv_em_memext)
            riscv_em_pkg::EXT_LB:
                o_riscv_em_loaddata = {{56{shifted[7]}}, shifted[7:0]};
            riscv_em_pkg::EXT_LH:
                o_riscv_em_loaddata = {{48{shifted[15]}}, shifted[15:0]};
            riscv_em_pkg::EXT_LW:
                o_riscv_em_loaddata = {{32{shifted[31]}}, shifted[31:0]};
            riscv_em_pkg::EXT_LD:
                o_riscv_em_loaddata = shifted;
            riscv_em_pkg::EXT_LBU:
                o_riscv_em_loaddata = {56'b0, shifted[7:0]};
            riscv_em_pkg::EXT_LHU:
                o_riscv_em_loaddata = {48'b0, shifted[15:0]};
            riscv_em_pkg::EXT_LWU:
                o_riscv_em_loaddata = {32'b0, shifted[31:0]};
            default:
                o_riscv_em_loaddata = '0;
        endcase
    end

endmodule
`default_nettype wire

//--- src/riscv_em_ctrl.sv
`default_nettype none
module riscv_em_ctrl (
    input  wire logic                   i_riscv_em_clk,
    input  wire logic                   i_riscv_em_rst,
    input  wire logic                   i_riscv_em_memread_m,
    input  wire logic                   i_riscv_em_memwrite_m,
    input  wire logic                   i_riscv_em_ecall_m_m,
    input  wire logic                   i_riscv_em_illegal_inst_m,
    input  wire logic                   i_riscv_em_load_addr_misaligned_m,
    input  wire logic                   i_riscv_em_store_addr_misaligned_m,
    output logic                        o_riscv_em_stall,
    output logic                        o_riscv_em_flush,
    output logic                        o_riscv_em_mem_we,
    output logic                        o_riscv_em_kill_m,
    output logic                        o_riscv_em_trap_m,
    output riscv_em_pkg::trap_cause_t   o_riscv_em_cause_m
);

    riscv_em_pkg::ctrl_state_t state_q;
    riscv_em_pkg::ctrl_state_t state_d;
    logic                      trap_any;

    assign trap_any = i_riscv_em_illegal_inst_m | i_riscv_em_ecall_m_m
                    | i_riscv_em_load_addr_misaligned_m | i_riscv_em_store_addr_misaligned_m;

    always_comb
    begin
        state_d = riscv_em_pkg::S_IDLE;
        if (state_q == riscv_em_pkg::S_IDLE && i_riscv_em_memread_m && !trap_any)
            state_d = riscv_em_pkg::S_LOAD_WAIT; // one wait cycle for the sync read
    end

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
            state_q <= riscv_em_pkg::S_IDLE;
        else
            state_q <= state_d;
    end

    always_comb
    begin
        if (i_riscv_em_illegal_inst_m) // highest priority
            o_riscv_em_cause_m = riscv_em_pkg::CAUSE_ILLEGAL;
        else if (i_riscv_em_ecall_m_m)
            o_riscv_em_cause_m = riscv_em_pkg::CAUSE_ECALL_M;
        else if (i_riscv_em_load_addr_misaligned_m)
            o_riscv_em_cause_m = riscv_em_pkg::CAUSE_LOAD_MISAL;
        else if (i_riscv_em_store_addr_misaligned_m)
            o_riscv_em_cause_m = riscv_em_pkg::CAUSE_STORE_MISAL;
        else
            o_riscv_em_cause_m = '0;
    end

    assign o_riscv_em_stall  = (state_d == riscv_em_pkg::S_LOAD_WAIT);
    assign o_riscv_em_flush  = trap_any; // drop the instruction behind the trap
    assign o_riscv_em_mem_we = i_riscv_em_memwrite_m & ~trap_any;
    assign o_riscv_em_kill_m = trap_any;
    assign o_riscv_em_trap_m = trap_any;

endmodule
`default_nettype wire

//--- src/riscv_em_mw_ppreg.sv
`default_nettype none
module riscv_em_mw_ppreg (
    input  wire logic                      i_riscv_em_clk,
    input  wire logic                      i_riscv_em_rst,
    input  wire logic                      i_riscv_em_stall,
    input  wire logic                      i_riscv_em_kill_m,
    input  wire logic                      i_riscv_em_trap_m,
    input  wire riscv_em_pkg::trap_cause_t i_riscv_em_cause_m,
    input  wire logic                      i_riscv_em_regw_m,
    input  wire riscv_em_pkg::resultsrc_t  i_riscv_em_resultsrc_m,
    input  wire riscv_em_pkg::regaddr_t    i_riscv_em_rdaddr_m,
    input  wire riscv_em_pkg::xlen_t       i_riscv_em_result_m,
    input  wire riscv_em_pkg::xlen_t       i_riscv_em_loaddata_m,
    input  wire riscv_em_pkg::xlen_t       i_riscv_em_pcplus4_m,
    input  wire riscv_em_pkg::xlen_t       i_riscv_em_imm_m,
    input  wire logic                      i_riscv_em_instret_m,
    output logic                           o_riscv_em_regw_w,
    output riscv_em_pkg::regaddr_t         o_riscv_em_rdaddr_w,
    output riscv_em_pkg::xlen_t            o_riscv_em_rddata_w,
    output logic                           o_riscv_em_instret_w,
    output logic                           o_riscv_em_trap_w,
    output riscv_em_pkg::trap_cause_t      o_riscv_em_cause_w
);

    riscv_em_pkg::xlen_t rddata_m;

    always_comb
    begin
        case (i_riscv_em_resultsrc_m)
            riscv_em_pkg::RES_ALU:     rddata_m = i_riscv_em_result_m;
            riscv_em_pkg::RES_LOAD:    rddata_m = i_riscv_em_loaddata_m;
            riscv_em_pkg::RES_PCPLUS4: rddata_m = i_riscv_em_pcplus4_m;
            default:                   rddata_m = i_riscv_em_imm_m;
        endcase
    end

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            o_riscv_em_regw_w    <= 1'b0;
            o_riscv_em_rdaddr_w  <= '0;
            o_riscv_em_rddata_w  <= '0;
            o_riscv_em_instret_w <= 1'b0;
            o_riscv_em_trap_w    <= 1'b0;
            o_riscv_em_cause_w   <= '0;
        end
        else if (i_riscv_em_stall) // bubble during the load wait
        begin
            o_riscv_em_regw_w    <= 1'b0;
            o_riscv_em_rdaddr_w  <= '0;
            o_riscv_em_rddata_w  <= '0;
            o_riscv_em_instret_w <= 1'b0;
            o_riscv_em_trap_w    <= 1'b0;
            o_riscv_em_cause_w   <= '0;
        end
        else
        begin
            o_riscv_em_regw_w    <= i_riscv_em_regw_m & ~i_riscv_em_kill_m;
            o_riscv_em_rdaddr_w  <= i_riscv_em_rdaddr_m;
            o_riscv_em_rddata_w  <= rddata_m;
            o_riscv_em_instret_w <= i_riscv_em_instret_m;
            o_riscv_em_trap_w    <= i_riscv_em_trap_m;
            o_riscv_em_cause_w   <= i_riscv_em_cause_m;
        end
    end

endmodule
`default_nettype wire

//--- src/riscv_em_mem_stage.sv
`default_nettype none
module riscv_em_mem_stage #(
    parameter int DMEM_WORDS = 64
) (
    input  wire logic                     i_riscv_em_clk,
    input  wire logic                     i_riscv_em_rst,
    input  wire logic                     i_riscv_em_regw_e,
    input  wire riscv_em_pkg::resultsrc_t i_riscv_em_resultsrc_e,
    input  wire riscv_em_pkg::storesrc_t  i_riscv_em_storesrc_e,
    input  wire riscv_em_pkg::memext_t    i_riscv_em_memext_e,
    input  wire logic                     i_riscv_em_memread_e,
    input  wire logic                     i_riscv_em_memwrite_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_pc_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_pcplus4_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_result_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_storedata_e,
    input  wire riscv_em_pkg::xlen_t      i_riscv_em_imm_e,
    input  wire riscv_em_pkg::regaddr_t   i_riscv_em_rdaddr_e,
    input  wire logic                     i_riscv_em_ecall_m_e,
    input  wire logic                     i_riscv_em_illegal_inst_e,
    input  wire logic                     i_riscv_em_load_addr_misaligned_e,
    input  wire logic                     i_riscv_em_store_addr_misaligned_e,
    input  wire logic                     i_riscv_em_instret_e,
    output logic                          o_riscv_em_stall,
    output logic                          o_riscv_em_regw_w,
    output riscv_em_pkg::regaddr_t        o_riscv_em_rdaddr_w,
    output riscv_em_pkg::xlen_t           o_riscv_em_rddata_w,
    output logic                          o_riscv_em_instret_w,
    output logic                          o_riscv_em_trap_w,
    output riscv_em_pkg::trap_cause_t     o_riscv_em_cause_w
);

    logic                      flush, mem_we, kill_m, trap_m;
    logic                      regw_m, memread_m, memwrite_m, instret_m;
    logic                      ecall_m, illegal_m, lmisal_m, smisal_m;
    riscv_em_pkg::trap_cause_t cause_m;
    riscv_em_pkg::resultsrc_t  resultsrc_m;
    riscv_em_pkg::storesrc_t   storesrc_m;
    riscv_em_pkg::memext_t     memext_m;
    riscv_em_pkg::regaddr_t    rdaddr_m;
    riscv_em_pkg::xlen_t       pcplus4_m, result_m, storedata_m, imm_m;
    riscv_em_pkg::xlen_t       wdata, rdata, loaddata_m;
    riscv_em_pkg::byteen_t     byteen;

    riscv_em_ctrl u_riscv_em_ctrl (
        .i_riscv_em_clk(i_riscv_em_clk), .i_riscv_em_rst(i_riscv_em_rst),
        .i_riscv_em_memread_m(memread_m), .i_riscv_em_memwrite_m(memwrite_m),
        .i_riscv_em_ecall_m_m(ecall_m), .i_riscv_em_illegal_inst_m(illegal_m),
        .i_riscv_em_load_addr_misaligned_m(lmisal_m),
        .i_riscv_em_store_addr_misaligned_m(smisal_m),
        .o_riscv_em_stall(o_riscv_em_stall), .o_riscv_em_flush(flush),
        .o_riscv_em_mem_we(mem_we), .o_riscv_em_kill_m(kill_m),
        .o_riscv_em_trap_m(trap_m), .o_riscv_em_cause_m(cause_m)
    );

    riscv_em_ppreg u_riscv_em_ppreg (
        .i_riscv_em_clk(i_riscv_em_clk), .i_riscv_em_rst(i_riscv_em_rst),
        .i_riscv_em_stall(o_riscv_em_stall), .i_riscv_em_flush(flush),
        .i_riscv_em_regw_e(i_riscv_em_regw_e), .i_riscv_em_resultsrc_e(i_riscv_em_resultsrc_e),
        .i_riscv_em_storesrc_e(i_riscv_em_storesrc_e), .i_riscv_em_memext_e(i_riscv_em_memext_e),
        .i_riscv_em_memread_e(i_riscv_em_memread_e),
        .i_riscv_em_memwrite_e(i_riscv_em_memwrite_e),
        .i_riscv_em_pc_e(i_riscv_em_pc_e), .i_riscv_em_pcplus4_e(i_riscv_em_pcplus4_e),
        .i_riscv_em_result_e(i_riscv_em_result_e),
        .i_riscv_em_storedata_e(i_riscv_em_storedata_e),
        .i_riscv_em_imm_e(i_riscv_em_imm_e), .i_riscv_em_rdaddr_e(i_riscv_em_rdaddr_e),
        .i_riscv_em_ecall_m_e(i_riscv_em_ecall_m_e),
        .i_riscv_em_illegal_inst_e(i_riscv_em_illegal_inst_e),
        .i_riscv_em_load_addr_misaligned_e(i_riscv_em_load_addr_misaligned_e),
        .i_riscv_em_store_addr_misaligned_e(i_riscv_em_store_addr_misaligned_e),
        .i_riscv_em_instret_e(i_riscv_em_instret_e),
        .o_riscv_em_pc_m(), // pc is not needed past M in this slice
        .o_riscv_em_regw_m(regw_m), .o_riscv_em_resultsrc_m(resultsrc_m),
        .o_riscv_em_storesrc_m(storesrc_m), .o_riscv_em_memext_m(memext_m),
        .o_riscv_em_memread_m(memread_m), .o_riscv_em_memwrite_m(memwrite_m),
        .o_riscv_em_pcplus4_m(pcplus4_m), .o_riscv_em_result_m(result_m),
        .o_riscv_em_storedata_m(storedata_m), .o_riscv_em_imm_m(imm_m),
        .o_riscv_em_rdaddr_m(rdaddr_m), .o_riscv_em_ecall_m_m(ecall_m),
        .o_riscv_em_illegal_inst_m(illegal_m),
        .o_riscv_em_load_addr_misaligned_m(lmisal_m),
        .o_riscv_em_store_addr_misaligned_m(smisal_m),
        .o_riscv_em_instret_m(instret_m)
    );

    riscv_em_store_align u_riscv_em_store_align (
        .i_riscv_em_storesrc(storesrc_m), .i_riscv_em_addr_lo(result_m[2:0]),
        .i_riscv_em_storedata(storedata_m),
        .o_riscv_em_byteen(byteen), .o_riscv_em_wdata(wdata)
    );

    riscv_em_dmem #(
        .DMEM_WORDS(DMEM_WORDS)
    ) u_riscv_em_dmem (
        .i_riscv_em_clk(i_riscv_em_clk), .i_riscv_em_we(mem_we),
        .i_riscv_em_byteen(byteen), .i_riscv_em_addr(result_m),
        .i_riscv_em_wdata(wdata), .o_riscv_em_rdata(rdata)
    );

    riscv_em_load_ext u_riscv_em_load_ext (
        .i_riscv_em_memext(memext_m), .i_riscv_em_addr_lo(result_m[2:0]),
        .i_riscv_em_rdata(rdata), .o_riscv_em_loaddata(loaddata_m)
    );

    riscv_em_mw_ppreg u_riscv_em_mw_ppreg (
        .i_riscv_em_clk(i_riscv_em_clk), .i_riscv_em_rst(i_riscv_em_rst),
        .i_riscv_em_stall(o_riscv_em_stall), .i_riscv_em_kill_m(kill_m),
        .i_riscv_em_trap_m(trap_m), .i_riscv_em_cause_m(cause_m),
        .i_riscv_em_regw_m(regw_m), .i_riscv_em_resultsrc_m(resultsrc_m),
        .i_riscv_em_rdaddr_m(rdaddr_m), .i_riscv_em_result_m(result_m),
        .i_riscv_em_loaddata_m(loaddata_m), .i_riscv_em_pcplus4_m(pcplus4_m),
        .i_riscv_em_imm_m(imm_m), .i_riscv_em_instret_m(instret_m),
        .o_riscv_em_regw_w(o_riscv_em_regw_w), .o_riscv_em_rdaddr_w(o_riscv_em_rdaddr_w),
        .o_riscv_em_rddata_w(o_riscv_em_rddata_w), .o_riscv_em_instret_w(o_riscv_em_instret_w),
        .o_riscv_em_trap_w(o_riscv_em_trap_w), .o_riscv_em_cause_w(o_riscv_em_cause_w)
    );

endmodule
`default_nettype wire

//--- tb/riscv_em_clkgen.sv
`default_nettype none
module riscv_em_clkgen (
    output logic o_riscv_em_clk
);

    initial
    begin
        o_riscv_em_clk = 1'b0;
    end

    always #4 o_riscv_em_clk = ~o_riscv_em_clk; // period 8

endmodule
`default_nettype wire

//--- tb/riscv_em_assertions.sv
`default_nettype none
module riscv_em_assertions (
    input wire logic i_riscv_em_clk,
    input wire logic i_riscv_em_rst,
    input wire logic i_riscv_em_stall,
    input wire logic i_riscv_em_flush,
    input wire logic i_riscv_em_mem_we,
    input wire logic i_riscv_em_illegal_inst_m,
    input wire logic i_riscv_em_ecall_m_m,
    input wire logic i_riscv_em_load_addr_misaligned_m,
    input wire logic i_riscv_em_store_addr_misaligned_m
);

    logic trap_flag;

    assign trap_flag = i_riscv_em_illegal_inst_m | i_riscv_em_ecall_m_m
                     | i_riscv_em_load_addr_misaligned_m
                     | i_riscv_em_store_addr_misaligned_m; // raw flags from the M stage

    stall_one_cycle: assert property (@(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_riscv_em_stall |=> !i_riscv_em_stall)
        else $error("stall held for two cycles");

    no_write_on_trap: assert property (@(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        !(i_riscv_em_mem_we && trap_flag))
        else $error("memory write together with a trap");

    flush_needs_trap: assert property (@(posedge i_riscv_em_clk) disable iff (i_riscv_em_rst)
        i_riscv_em_flush |-> trap_flag)
        else $error("flush without a trap");

endmodule

bind riscv_em_ctrl riscv_em_assertions u_riscv_em_assertions (
    .i_riscv_em_clk(i_riscv_em_clk), .i_riscv_em_rst(i_riscv_em_rst),
    .i_riscv_em_stall(o_riscv_em_stall), .i_riscv_em_flush(o_riscv_em_flush),
    .i_riscv_em_mem_we(o_riscv_em_mem_we),
    .i_riscv_em_illegal_inst_m(i_riscv_em_illegal_inst_m),
    .i_riscv_em_ecall_m_m(i_riscv_em_ecall_m_m),
    .i_riscv_em_load_addr_misaligned_m(i_riscv_em_load_addr_misaligned_m),
    .i_riscv_em_store_addr_misaligned_m(i_riscv_em_store_addr_misaligned_m)
);
`default_nettype wire

//--- tb/riscv_em_tb.sv
`default_nettype none
module riscv_em_tb;

    typedef struct {
        logic                      mr;
        logic                      mw;
        riscv_em_pkg::memext_t     ext;
        riscv_em_pkg::storesrc_t   sz;
        riscv_em_pkg::resultsrc_t  rsrc;
        riscv_em_pkg::regaddr_t    rd;
        riscv_em_pkg::xlen_t       addr, a, b, c;
        logic [3:0]                flags; // illegal, ecall, load misal, store misal
        riscv_em_pkg::trap_cause_t cause;
        logic                      follow;
    } op_t;

    logic clk, rst, regw_e, memread_e, memwrite_e, ecall_e, illegal_e, lmis_e, smis_e, instret_e;
    riscv_em_pkg::resultsrc_t  resultsrc_e;
    riscv_em_pkg::storesrc_t   storesrc_e;
    riscv_em_pkg::memext_t     memext_e;
    riscv_em_pkg::xlen_t       pc_e, pcplus4_e, result_e, storedata_e, imm_e, rddata_w;
    riscv_em_pkg::regaddr_t    rdaddr_e, rdaddr_w;
    logic                      stall, regw_w, instret_w, trap_w;
    riscv_em_pkg::trap_cause_t cause_w;
    op_t                       ops [64];
    logic [7:0]                mem_model [512];
    logic [31:0]               lcg_state = 32'haded_5f1d;
    int                        n = 0;
    int                        errors = 0;
    int                        cycles = 0;
    int                        limit = 0;

    riscv_em_clkgen u_riscv_em_clkgen (.o_riscv_em_clk(clk));

    riscv_em_mem_stage #(.DMEM_WORDS(64)) u_riscv_em_mem_stage (
        .i_riscv_em_clk(clk), .i_riscv_em_rst(rst), .i_riscv_em_regw_e(regw_e),
        .i_riscv_em_resultsrc_e(resultsrc_e), .i_riscv_em_storesrc_e(storesrc_e),
        .i_riscv_em_memext_e(memext_e), .i_riscv_em_memread_e(memread_e),
        .i_riscv_em_memwrite_e(memwrite_e), .i_riscv_em_pc_e(pc_e),
        .i_riscv_em_pcplus4_e(pcplus4_e), .i_riscv_em_result_e(result_e),
        .i_riscv_em_storedata_e(storedata_e), .i_riscv_em_imm_e(imm_e),
        .i_riscv_em_rdaddr_e(rdaddr_e), .i_riscv_em_ecall_m_e(ecall_e),
        .i_riscv_em_illegal_inst_e(illegal_e), .i_riscv_em_load_addr_misaligned_e(lmis_e),
        .i_riscv_em_store_addr_misaligned_e(smis_e), .i_riscv_em_instret_e(instret_e),
        .o_riscv_em_stall(stall), .o_riscv_em_regw_w(regw_w), .o_riscv_em_rdaddr_w(rdaddr_w),
        .o_riscv_em_rddata_w(rddata_w), .o_riscv_em_instret_w(instret_w),
        .o_riscv_em_trap_w(trap_w), .o_riscv_em_cause_w(cause_w)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_off(input int sz); // aligned offset in the 64-byte region
        return int'((next_rand() >> 8) % (32'd64 >> sz)) << sz;
    endfunction

    function automatic riscv_em_pkg::xlen_t load_model(input int addr, input int ext);
        riscv_em_pkg::xlen_t v;
        int                  nb;
        v = '0;
        nb = 1 << (ext < 4 ? ext : ext - 4);
        for (int b = 0; b < nb; b++)
            v[8*b +: 8] = mem_model[addr + b];
        if (ext < 3 && v[8*nb-1])
            v = v | (~64'd0 << (8 * nb)); // sign fill
        return v;
    endfunction

    task automatic add_op(input logic mr, input logic mw, input int ext, input int sz,
                          input int rsrc, input logic [3:0] flags, input int cause,
                          input logic follow, input int addr);
        ops[n].mr = mr;
        ops[n].mw = mw;
        ops[n].ext = riscv_em_pkg::memext_t'(ext);
        ops[n].sz = riscv_em_pkg::storesrc_t'(sz);
        ops[n].rsrc = riscv_em_pkg::resultsrc_t'(rsrc);
        ops[n].rd = riscv_em_pkg::regaddr_t'(n % 31 + 1);
        ops[n].addr = riscv_em_pkg::xlen_t'(addr);
        ops[n].a = {next_rand(), next_rand()};
        ops[n].b = {next_rand(), next_rand()};
        ops[n].c = {next_rand(), next_rand()};
        ops[n].flags = flags;
        ops[n].cause = riscv_em_pkg::trap_cause_t'(cause);
        ops[n].follow = follow;
        n++;
    endtask

    task automatic drive_op(input op_t op);
        regw_e = ~op.mw;
        resultsrc_e = op.rsrc;
        storesrc_e = op.sz;
        memext_e = op.ext;
        memread_e = op.mr;
        memwrite_e = op.mw;
        pc_e = op.b;
        pcplus4_e = op.b + 64'd4;
        result_e = (op.mr | op.mw) ? op.addr : op.a;
        storedata_e = op.a;
        imm_e = op.c;
        rdaddr_e = op.rd;
        {illegal_e, ecall_e, lmis_e, smis_e} = op.flags;
        instret_e = 1'b1;
    endtask

    task automatic drive_bubble();
        regw_e = 1'b0;
        resultsrc_e = '0;
        storesrc_e = '0;
        memext_e = '0;
        memread_e = 1'b0;
        memwrite_e = 1'b0;
        pc_e = '0;
        pcplus4_e = '0;
        result_e = '0;
        storedata_e = '0;
        imm_e = '0;
        rdaddr_e = '0;
        {illegal_e, ecall_e, lmis_e, smis_e} = 4'b0;
        instret_e = 1'b0;
    endtask

    task automatic report_mismatch(input string name, input riscv_em_pkg::xlen_t exp,
                                   input riscv_em_pkg::xlen_t act);
        $display("Fail at %0t: %s expected %h actual %h", $time, name, exp, act);
        errors++;
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles > limit)
        begin
            $display("timeout: the DUT did not finish within %0d cycles", limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial
    begin
        int                  stalls, lat, err_before;
        logic                exp_load, exp_trap, exp_regw;
        riscv_em_pkg::xlen_t exp_data;
        rst = 1'b1;
        drive_bubble();
        for (int w = 0; w < 8; w++)
            add_op(0, 1, 0, 3, 0, 4'b0, 0, 0, w * 8); // fill the test region first
        for (int r = 0; r < 6; r++)
            add_op(0, 0, 0, 0, (r % 3 == 0) ? 0 : (r % 3) + 1, 4'b0, 0, 0, 0);
        for (int s = 0; s < 4; s++)
        begin
            add_op(0, 1, 0, s, 0, 4'b0, 0, 0, rand_off(s));
            for (int e = 0; e < 7; e++)
                add_op(1, 0, e, 0, 1, 4'b0, 0, 0, rand_off(e < 4 ? e : e - 4));
        end
        add_op(0, 1, 0, 0, 0, 4'b0, 0, 0, 29);       // single byte inside word 3
        add_op(1, 0, 3, 0, 1, 4'b0, 0, 0, 24);
        add_op(0, 0, 0, 0, 0, 4'b1000, 2, 1, 0);     // illegal with a follower right behind
        add_op(0, 0, 0, 0, 0, 4'b0100, 11, 1, 0);
        add_op(1, 0, 3, 0, 1, 4'b0010, 4, 0, 8);
        add_op(0, 1, 0, 3, 0, 4'b0001, 6, 0, 16);    // store that must not land
        add_op(1, 0, 3, 0, 1, 4'b0, 0, 0, 16);
        add_op(0, 0, 0, 0, 0, 4'b0110, 11, 0, 0);
        add_op(0, 1, 0, 3, 0, 4'b1001, 2, 1, 40);
        add_op(1, 0, 3, 0, 1, 4'b0, 0, 0, 40);
        limit = 10 * n + 50;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        if (stall !== 1'b0) report_mismatch("o_riscv_em_stall", 0, 64'(stall));
        if (trap_w !== 1'b0) report_mismatch("o_riscv_em_trap_w", 0, 64'(trap_w));
        if (regw_w !== 1'b0) report_mismatch("o_riscv_em_regw_w", 0, 64'(regw_w));
        if (instret_w !== 1'b0) report_mismatch("o_riscv_em_instret_w", 0, 64'(instret_w));
        $display("reset check %s", errors == 0 ? "ok" : "failed");
        for (int i = 0; i < n; i++)
        begin
            err_before = errors;
            exp_trap = ops[i].flags != 4'b0;
            exp_load = ops[i].mr && !exp_trap;
            exp_regw = !exp_trap && !ops[i].mw;
            case (ops[i].rsrc)
                2'd0: exp_data = ops[i].a;
                2'd2: exp_data = ops[i].b + 64'd4;
                default: exp_data = ops[i].c;
            endcase
            if (ops[i].mr)
                exp_data = load_model(int'(ops[i].addr), int'(ops[i].ext));
            if (ops[i].mw && !exp_trap)
                for (int b = 0; b < (1 << ops[i].sz); b++)
                    mem_model[int'(ops[i].addr) + b] = ops[i].a[8*b +: 8];
            drive_op(ops[i]);
            stalls = 0;
            @(posedge clk);
            #1 lat = 1;
            while (stall)
            begin
                stalls++;
                @(posedge clk);
                #1 lat++;
            end
            if (ops[i].follow)
                drive_op(ops[i]); // second copy right behind the trap
            else
                drive_bubble();
            @(posedge clk);
            #1 lat++;
            drive_bubble();
            while (!instret_w && lat < 8)
            begin
                @(posedge clk);
                #1 lat++;
            end
            if (!instret_w)
            begin
                $display("test %0d: the instruction never retired", i);
                errors++;
            end
            if (lat != (exp_load ? 3 : 2))
                report_mismatch("latency", exp_load ? 3 : 2, lat);
            if (stalls != (exp_load ? 1 : 0))
                report_mismatch("o_riscv_em_stall", 64'(exp_load), stalls);
            if (trap_w !== exp_trap)
                report_mismatch("o_riscv_em_trap_w", 64'(exp_trap), 64'(trap_w));
            if (exp_trap && cause_w !== ops[i].cause)
                report_mismatch("o_riscv_em_cause_w", ops[i].cause, cause_w);
            if (regw_w !== exp_regw)
                report_mismatch("o_riscv_em_regw_w", 64'(exp_regw), 64'(regw_w));
            if (exp_regw && rdaddr_w !== ops[i].rd)
                report_mismatch("o_riscv_em_rdaddr_w", ops[i].rd, rdaddr_w);
            if (exp_regw && rddata_w !== exp_data)
                report_mismatch("o_riscv_em_rddata_w", exp_data, rddata_w);
            @(posedge clk);
            #1;
            if (instret_w !== 1'b0) report_mismatch("o_riscv_em_instret_w", 0, 64'(instret_w));
            if (trap_w !== 1'b0) report_mismatch("o_riscv_em_trap_w", 0, 64'(trap_w));
            $display("test %0d %s", i, errors == err_before ? "ok" : "failed");
        end
        $display("tests run %0d, errors %0d", n, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule
`default_nettype wire

//--- filelist.f
src/riscv_em_pkg.sv
src/riscv_em_ppreg.sv
src/riscv_em_store_align.sv
src/riscv_em_dmem.sv
src/riscv_em_load_ext.sv
src/riscv_em_ctrl.sv
src/riscv_em_mw_ppreg.sv
src/riscv_em_mem_stage.sv
tb/riscv_em_clkgen.sv
tb/riscv_em_assertions.sv
tb/riscv_em_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench, then scan the log
verilator --binary --timing --assert -f filelist.f --top-module riscv_em_tb \
    -o riscv_em_sim > build.log 2>&1 \
    && ./obj_dir/riscv_em_sim > sim.log 2>&1 \
    || { echo "build or simulation error, see build.log and sim.log"; exit 1; }
grep -q '\*\*\* FAILED \*\*\*' sim.log \
    && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
